// ==== src/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ========================================
// cache geometry
// ========================================

// physical address width
`define DC_ADDR_W 32

// two ways only, the replacement state is a single bit per set
`define DC_WAYS 2

// 16 sets
`define DC_IDX_W 4

// 16-byte lines of 32-bit words
`define DC_WORDS 4
`define DC_OFS_W 4

// whatever is left above index and offset
`define DC_TAG_W 24

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

  // ========================================
  // request encodings
  // ========================================

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // ========================================
  // array contents
  // ========================================

  typedef logic [`DC_TAG_W-1:0] dc_tag_t;
  typedef logic [`DC_IDX_W-1:0] dc_idx_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] dc_way_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } dc_meta_t;

  typedef logic [`DC_WORDS-1:0][31:0] dc_line_t;

endpackage

// ==== src/dcache_sdp_ram.sv ====
module dcache_sdp_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // write-first: a read of the address being written sees the new word
  always_ff @(posedge clk) begin
    if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// ==== src/dcache_arrays.sv ====
`include "dcache_consts.svh"

module dcache_arrays
  import dcache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  dc_idx_t                   rd_idx_i,
  input  logic                      refill_we_i,
  input  dc_way_t                   refill_way_i,
  input  dc_idx_t                   refill_idx_i,
  input  dc_tag_t                   refill_tag_i,
  input  dc_line_t                  refill_line_i,
  input  logic                      store_we_i,
  input  dc_way_t                   store_way_i,
  input  dc_idx_t                   store_idx_i,
  input  dc_line_t                  store_line_i,
  output dc_tag_t  [`DC_WAYS-1:0]   tag_o,
  output dc_meta_t [`DC_WAYS-1:0]   meta_o,
  output dc_line_t [`DC_WAYS-1:0]   line_o
);

  // ========================================
  // shared write port
  // ========================================

  logic     wr_any;
  dc_way_t  wr_way;
  dc_idx_t  wr_idx;
  dc_line_t wr_line;
  dc_meta_t wr_meta;

  // refill first, store hit otherwise
  assign wr_any  = refill_we_i | store_we_i;
  assign wr_way  = refill_we_i ? refill_way_i : store_way_i;
  assign wr_idx  = refill_we_i ? refill_idx_i : store_idx_i;
  assign wr_line = refill_we_i ? refill_line_i : store_line_i;
  // a refilled line is clean, a store hit leaves it dirty
  assign wr_meta = '{valid: 1'b1, dirty: ~refill_we_i};

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    logic                     line_we;
    logic                     tag_we;
    logic [2**`DC_IDX_W-1:0]  vld_q;
    logic                     vld_rd;
    dc_meta_t                 meta_rd;

    assign line_we = wr_any & (wr_way == dc_way_t'(w));
    assign tag_we  = refill_we_i & (refill_way_i == dc_way_t'(w));

    dcache_sdp_ram #(
      .DEPTH(2**`DC_IDX_W),
      .WIDTH($bits(dc_line_t))
    ) u_data_ram (
      .clk    (clk),
      .we_i   (line_we),
      .waddr_i(wr_idx),
      .wdata_i(wr_line),
      .raddr_i(rd_idx_i),
      .rdata_o(line_o[w])
    );

    dcache_sdp_ram #(
      .DEPTH(2**`DC_IDX_W),
      .WIDTH($bits(dc_tag_t))
    ) u_tag_ram (
      .clk    (clk),
      .we_i   (tag_we),
      .waddr_i(refill_idx_i),
      .wdata_i(refill_tag_i),
      .raddr_i(rd_idx_i),
      .rdata_o(tag_o[w])
    );

    dcache_sdp_ram #(
      .DEPTH(2**`DC_IDX_W),
      .WIDTH($bits(dc_meta_t))
    ) u_meta_ram (
      .clk    (clk),
      .we_i   (line_we),
      .waddr_i(wr_idx),
      .wdata_i(wr_meta),
      .raddr_i(rd_idx_i),
      .rdata_o(meta_rd)
    );

    // valid bits live in flops so the cache comes up empty
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q  <= '0;
        vld_rd <= 1'b0;
      end else begin
        if (tag_we) begin
          vld_q[refill_idx_i] <= 1'b1;
        end
        vld_rd <= (tag_we && refill_idx_i == rd_idx_i) ? 1'b1 : vld_q[rd_idx_i];
      end
    end

    assign meta_o[w] = '{valid: meta_rd.valid & vld_rd, dirty: meta_rd.dirty};
  end

  // refill only runs while stage 2 misses, store writes only on a hit
  a_no_write_clash : assert property (
    @(posedge clk) disable iff (!rst_n) !(refill_we_i && store_we_i)
  );

endmodule

// ==== src/dcache_lookup.sv ====
`include "dcache_consts.svh"

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic                     req_we_i,
  input  mem_size_e                req_size_i,
  input  logic                     req_unsigned_i,
  input  logic [`DC_ADDR_W-1:0]    req_addr_i,
  input  logic [31:0]              req_wdata_i,
  input  logic                     s2_ready_i,
  input  logic [`DC_ADDR_W-1:0]    s2_addr_i,
  output dc_idx_t                  rd_idx_o,
  input  dc_tag_t  [`DC_WAYS-1:0]  tag_i,
  input  dc_meta_t [`DC_WAYS-1:0]  meta_i,
  output logic                     s1_valid_o,
  output logic                     s1_we_o,
  output mem_size_e                s1_size_o,
  output logic                     s1_unsigned_o,
  output logic [`DC_ADDR_W-1:0]    s1_addr_o,
  output logic [31:0]              s1_wdata_o,
  output logic                     hit_o,
  output dc_way_t                  hit_way_o,
  output dc_way_t                  victim_way_o,
  output dc_tag_t                  victim_tag_o,
  output logic                     victim_dirty_o
);

  logic                    s2_vld;
  dc_idx_t                 s2_idx;
  dc_tag_t                 s2_tag;
  logic [`DC_WAYS-1:0]     way_match;
  logic [2**`DC_IDX_W-1:0] plru_q;

  // ========================================
  // stage 1 register
  // ========================================

  assign req_ready_o = ~s1_valid_o | s2_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_o <= 1'b0;
      s2_vld     <= 1'b0;
    end else begin
      if (req_ready_o) begin
        s1_valid_o <= req_valid_i;
      end
      // local copy of the stage-2 valid, gates hit and PLRU update
      if (s2_ready_i) begin
        s2_vld <= s1_valid_o;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      s1_we_o       <= req_we_i;
      s1_size_o     <= req_size_i;
      s1_unsigned_o <= req_unsigned_i;
      s1_addr_o     <= req_addr_i;
      s1_wdata_o    <= req_wdata_i;
    end
  end

  // read the next set when stage 1 moves on, else keep re-reading stage 2
  assign s2_idx   = s2_addr_i[`DC_OFS_W +: `DC_IDX_W];
  assign s2_tag   = s2_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign rd_idx_o = s2_ready_i ? s1_addr_o[`DC_OFS_W +: `DC_IDX_W] : s2_idx;

  // ========================================
  // tag compare and replacement
  // ========================================

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_match[w] = meta_i[w].valid && tag_i[w] == s2_tag;
      if (way_match[w]) begin
        hit_way_o = dc_way_t'(w);
      end
    end
  end

  assign hit_o = s2_vld & (|way_match);

  assign victim_way_o   = plru_q[s2_idx];
  assign victim_tag_o   = tag_i[victim_way_o];
  assign victim_dirty_o = meta_i[victim_way_o].valid & meta_i[victim_way_o].dirty;

  // a hit always completes stage 2, point the set at the other way
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      plru_q <= '0;
    end else if (hit_o) begin
      plru_q[s2_idx] <= ~hit_way_o;
    end
  end

  a_req_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_valid_i && req_ready_o) |->
      ((req_size_i == SIZE_HALF) ? !req_addr_i[0] :
       (req_size_i == SIZE_WORD) ? (req_addr_i[1:0] == 2'b00) : 1'b1)
  );

endmodule

// ==== src/dcache_access.sv ====
`include "dcache_consts.svh"

module dcache_access
  import dcache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s1_valid_i,
  input  logic                     s1_we_i,
  input  mem_size_e                s1_size_i,
  input  logic                     s1_unsigned_i,
  input  logic [`DC_ADDR_W-1:0]    s1_addr_i,
  input  logic [31:0]              s1_wdata_i,
  output logic                     s2_ready_o,
  output logic [`DC_ADDR_W-1:0]    s2_addr_o,
  input  logic                     hit_i,
  input  dc_way_t                  hit_way_i,
  input  dc_line_t [`DC_WAYS-1:0]  line_i,
  output logic                     miss_o,
  output logic                     store_we_o,
  output dc_way_t                  store_way_o,
  output dc_idx_t                  store_idx_o,
  output dc_line_t                 store_line_o,
  output logic                     rsp_valid_o,
  output logic [31:0]              rsp_rdata_o
);

  logic                       s2_valid;
  logic                       s2_we;
  mem_size_e                  s2_size;
  logic                       s2_unsigned;
  logic [31:0]                s2_wdata;
  dc_line_t                   hit_line;
  logic [$clog2(`DC_WORDS)-1:0] word_idx;
  logic [31:0]                word;
  logic [31:0]                shifted;
  logic [31:0]                load_data;
  logic [3:0]                 byte_en;
  logic [31:0]                wdata_sh;
  logic [31:0]                merged;

  // ========================================
  // stage 2 register
  // ========================================

  // a missing item parks here until the refill makes it hit
  assign s2_ready_o = ~s2_valid | hit_i;
  assign miss_o     = s2_valid & ~hit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_ready_o) begin
      s2_valid <= s1_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready_o && s1_valid_i) begin
      s2_we       <= s1_we_i;
      s2_size     <= s1_size_i;
      s2_unsigned <= s1_unsigned_i;
      s2_addr_o   <= s1_addr_i;
      s2_wdata    <= s1_wdata_i;
    end
  end

  assign hit_line = line_i[hit_way_i];
  assign word_idx = s2_addr_o[`DC_OFS_W-1:2];
  assign word     = hit_line[word_idx];

  // ========================================
  // load path
  // ========================================

  assign shifted = word >> {s2_addr_o[1:0], 3'b000};

  always_comb begin
    case (s2_size)
      SIZE_BYTE: load_data = {{24{~s2_unsigned & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_data = {{16{~s2_unsigned & shifted[15]}}, shifted[15:0]};
      default:   load_data = shifted;
    endcase
  end

  // ========================================
  // store path
  // ========================================

  always_comb begin
    case (s2_size)
      SIZE_BYTE: byte_en = 4'b0001 << s2_addr_o[1:0];
      SIZE_HALF: byte_en = 4'b0011 << s2_addr_o[1:0];
      default:   byte_en = 4'b1111;
    endcase
  end

  assign wdata_sh = s2_wdata << {s2_addr_o[1:0], 3'b000};

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged[b*8 +: 8] = byte_en[b] ? wdata_sh[b*8 +: 8] : word[b*8 +: 8];
    end
    store_line_o           = hit_line;
    store_line_o[word_idx] = merged;
  end

  assign store_we_o  = hit_i & s2_we;
  assign store_way_o = hit_way_i;
  assign store_idx_o = s2_addr_o[`DC_OFS_W +: `DC_IDX_W];

  // one response per item, stores included
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= hit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_i) begin
      rsp_rdata_o <= load_data;
    end
  end

endmodule

// ==== src/dcache_miss_fsm.sv ====
`include "dcache_consts.svh"

module dcache_miss_fsm
  import dcache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     miss_i,
  input  logic [`DC_ADDR_W-1:0]    s2_addr_i,
  input  dc_way_t                  victim_way_i,
  input  dc_tag_t                  victim_tag_i,
  input  logic                     victim_dirty_i,
  input  dc_line_t [`DC_WAYS-1:0]  line_i,
  output logic                     refill_we_o,
  output dc_way_t                  refill_way_o,
  output dc_idx_t                  refill_idx_o,
  output dc_tag_t                  refill_tag_o,
  output dc_line_t                 refill_line_o,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [`DC_ADDR_W-1:0]    mem_addr_o,
  output logic [31:0]              mem_wdata_o,
  input  logic                     mem_ack_i,
  input  logic [31:0]              mem_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    REFILL
  } state_e;

  localparam int CNT_W = $clog2(`DC_WORDS);

  state_e                        state_q;
  logic [CNT_W-1:0]              cnt_q;
  logic                          last_word;
  logic [`DC_WORDS-2:0][31:0]    buf_q;
  dc_line_t                      victim_line;

  // victim way, tag and line stay put while stage 2 is stalled on the miss
  assign victim_line  = line_i[victim_way_i];
  assign last_word    = cnt_q == CNT_W'(`DC_WORDS - 1);
  assign refill_idx_o = s2_addr_i[`DC_OFS_W +: `DC_IDX_W];
  assign refill_tag_o = s2_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign refill_way_o = victim_way_i;

  // ========================================
  // sequencer
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (miss_i) begin
            state_q <= victim_dirty_i ? WRITE_BACK : REFILL;
          end
        end
        WRITE_BACK: begin
          if (mem_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= REFILL;
            end
          end
        end
        REFILL: begin
          if (mem_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // words arriving before the last one
  always_ff @(posedge clk) begin
    if (state_q == REFILL && mem_ack_i && !last_word) begin
      buf_q[cnt_q] <= mem_rdata_i;
    end
  end

  // last word goes straight into the array with the buffered ones
  assign refill_we_o   = (state_q == REFILL) & mem_ack_i & last_word;
  assign refill_line_o = {mem_rdata_i, buf_q};

  // ========================================
  // memory bus
  // ========================================

  assign mem_req_o   = state_q != IDLE;
  assign mem_we_o    = state_q == WRITE_BACK;
  assign mem_wdata_o = victim_line[cnt_q];

  always_comb begin
    if (state_q == WRITE_BACK) begin
      mem_addr_o = {victim_tag_i, refill_idx_o, cnt_q, 2'b00};
    end else begin
      mem_addr_o = {refill_tag_o, refill_idx_o, cnt_q, 2'b00};
    end
  end

  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (!rst_n) mem_ack_i |-> mem_req_o
  );

endmodule

// ==== src/dcache_top.sv ====
`include "dcache_consts.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // core port
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  mem_size_e              req_size_i,
  input  logic                   req_unsigned_i,
  input  logic [`DC_ADDR_W-1:0]  req_addr_i,
  input  logic [31:0]            req_wdata_i,
  output logic                   rsp_valid_o,
  output logic [31:0]            rsp_rdata_o,
  // memory port
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`DC_ADDR_W-1:0]  mem_addr_o,
  output logic [31:0]            mem_wdata_o,
  input  logic                   mem_ack_i,
  input  logic [31:0]            mem_rdata_i
);

  dc_idx_t                  rd_idx;
  dc_tag_t  [`DC_WAYS-1:0]  tag;
  dc_meta_t [`DC_WAYS-1:0]  meta;
  dc_line_t [`DC_WAYS-1:0]  line;

  logic                     s1_valid;
  logic                     s1_we;
  mem_size_e                s1_size;
  logic                     s1_unsigned;
  logic [`DC_ADDR_W-1:0]    s1_addr;
  logic [31:0]              s1_wdata;
  logic                     s2_ready;
  logic [`DC_ADDR_W-1:0]    s2_addr;

  logic                     hit;
  dc_way_t                  hit_way;
  dc_way_t                  victim_way;
  dc_tag_t                  victim_tag;
  logic                     victim_dirty;
  logic                     miss;

  logic                     store_we;
  dc_way_t                  store_way;
  dc_idx_t                  store_idx;
  dc_line_t                 store_line;
  logic                     refill_we;
  dc_way_t                  refill_way;
  dc_idx_t                  refill_idx;
  dc_tag_t                  refill_tag;
  dc_line_t                 refill_line;

  dcache_lookup u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_we_i      (req_we_i),
    .req_size_i    (req_size_i),
    .req_unsigned_i(req_unsigned_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .s2_ready_i    (s2_ready),
    .s2_addr_i     (s2_addr),
    .rd_idx_o      (rd_idx),
    .tag_i         (tag),
    .meta_i        (meta),
    .s1_valid_o    (s1_valid),
    .s1_we_o       (s1_we),
    .s1_size_o     (s1_size),
    .s1_unsigned_o (s1_unsigned),
    .s1_addr_o     (s1_addr),
    .s1_wdata_o    (s1_wdata),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way),
    .victim_tag_o  (victim_tag),
    .victim_dirty_o(victim_dirty)
  );

  dcache_access u_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .s1_valid_i   (s1_valid),
    .s1_we_i      (s1_we),
    .s1_size_i    (s1_size),
    .s1_unsigned_i(s1_unsigned),
    .s1_addr_i    (s1_addr),
    .s1_wdata_i   (s1_wdata),
    .s2_ready_o   (s2_ready),
    .s2_addr_o    (s2_addr),
    .hit_i        (hit),
    .hit_way_i    (hit_way),
    .line_i       (line),
    .miss_o       (miss),
    .store_we_o   (store_we),
    .store_way_o  (store_way),
    .store_idx_o  (store_idx),
    .store_line_o (store_line),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o)
  );

  dcache_miss_fsm u_miss_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_i        (miss),
    .s2_addr_i     (s2_addr),
    .victim_way_i  (victim_way),
    .victim_tag_i  (victim_tag),
    .victim_dirty_i(victim_dirty),
    .line_i        (line),
    .refill_we_o   (refill_we),
    .refill_way_o  (refill_way),
    .refill_idx_o  (refill_idx),
    .refill_tag_o  (refill_tag),
    .refill_line_o (refill_line),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  dcache_arrays u_arrays (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_idx_i     (rd_idx),
    .refill_we_i  (refill_we),
    .refill_way_i (refill_way),
    .refill_idx_i (refill_idx),
    .refill_tag_i (refill_tag),
    .refill_line_i(refill_line),
    .store_we_i   (store_we),
    .store_way_i  (store_way),
    .store_idx_i  (store_idx),
    .store_line_i (store_line),
    .tag_o        (tag),
    .meta_o       (meta),
    .line_o       (line)
  );

endmodule

// ==== tb/tb_dcache.sv ====
`include "dcache_consts.svh"

module tb_dcache
  import dcache_pkg::*;
;

  localparam int NUM_REQS   = 2000;
  localparam int MAX_CYCLES = NUM_REQS * 40;
  localparam int MEM_WORDS  = 2048;
  localparam int NUM_SETS   = 2**`DC_IDX_W;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid_i;
  logic                  req_ready_o;
  logic                  req_we_i;
  mem_size_e             req_size_i;
  logic                  req_unsigned_i;
  logic [`DC_ADDR_W-1:0] req_addr_i;
  logic [31:0]           req_wdata_i;
  logic                  rsp_valid_o;
  logic [31:0]           rsp_rdata_o;
  logic                  mem_req_o;
  logic                  mem_we_o;
  logic [`DC_ADDR_W-1:0] mem_addr_o;
  logic [31:0]           mem_wdata_o;
  logic                  mem_ack_i;
  logic [31:0]           mem_rdata_i;

  // 8 KB backing store and the architectural byte image
  logic [31:0]           ext_mem [MEM_WORDS];
  logic [7:0]            shadow [4*MEM_WORDS];

  // tag model
  logic [`DC_TAG_W-1:0]  m_tag [NUM_SETS][`DC_WAYS];
  logic                  m_valid [NUM_SETS][`DC_WAYS];
  logic                  m_dirty [NUM_SETS][`DC_WAYS];
  logic                  m_plru [NUM_SETS];

  // expected responses, in request order
  logic                  exp_is_load [$];
  logic [31:0]           exp_data [$];
  logic                  exp_hit [$];
  int unsigned           exp_acc [$];

  // expected bus transfers
  logic                  exp_mem_we [$];
  logic [31:0]           exp_mem_addr [$];
  logic [31:0]           exp_mem_data [$];

  logic [31:0]           stim_rnd = 32'hdcb2;
  logic [31:0]           mem_rnd = ~32'hdcb2;
  int unsigned           cycle_cnt = 0;
  int unsigned           last_rsp = 0;

  dcache_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_we_i      (req_we_i),
    .req_size_i    (req_size_i),
    .req_unsigned_i(req_unsigned_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim_rand();
    stim_rnd = lcg_step(stim_rnd);
    return stim_rnd;
  endfunction

  function automatic logic [31:0] fill_word(input int unsigned i);
    return (i * 32'h9e3779b1) ^ (i << 13) ^ 32'h2468ace1;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [12:0] a);
    return {shadow[{a[12:2], 2'd3}], shadow[{a[12:2], 2'd2}],
            shadow[{a[12:2], 2'd1}], shadow[{a[12:2], 2'd0}]};
  endfunction

  // little-endian lanes, sign or zero extension
  function automatic logic [31:0] load_value(input mem_size_e sz, input logic uns,
                                             input logic [12:0] a);
    logic [15:0] h;
    h = {shadow[a + 13'd1], shadow[a]};
    case (sz)
      SIZE_BYTE: return {{24{~uns & shadow[a][7]}}, shadow[a]};
      SIZE_HALF: return {{16{~uns & h[15]}}, h};
      default:   return shadow_word(a);
    endcase
  endfunction

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  // ========================================
  // reference model, run at acceptance
  // ========================================

  task automatic predict(input logic we, input mem_size_e sz, input logic uns,
                         input logic [31:0] addr, input logic [31:0] wd);
    logic [`DC_IDX_W-1:0] idx;
    logic [`DC_TAG_W-1:0] tag;
    logic                 way;
    logic                 hit;
    logic [31:0]          wb_addr;
    int                   k;
    int                   w;
    idx = addr[7:4];
    tag = addr[31:8];
    hit = 1'b0;
    way = 1'b0;
    for (w = 0; w < `DC_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = m_plru[idx];
      // dirty victim goes out before the refill
      if (m_valid[idx][way] && m_dirty[idx][way]) begin
        for (k = 0; k < `DC_WORDS; k++) begin
          wb_addr = {m_tag[idx][way], idx, k[1:0], 2'b00};
          exp_mem_we.push_back(1'b1);
          exp_mem_addr.push_back(wb_addr);
          exp_mem_data.push_back(shadow_word(wb_addr[12:0]));
        end
      end
      for (k = 0; k < `DC_WORDS; k++) begin
        exp_mem_we.push_back(1'b0);
        exp_mem_addr.push_back({addr[31:4], k[1:0], 2'b00});
        exp_mem_data.push_back(32'h0);
      end
      m_tag[idx][way]   = tag;
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = 1'b0;
    end
    m_plru[idx] = ~way;
    if (we) begin
      m_dirty[idx][way] = 1'b1;
      case (sz)
        SIZE_BYTE: shadow[addr[12:0]] = wd[7:0];
        SIZE_HALF: begin
          shadow[addr[12:0]]         = wd[7:0];
          shadow[addr[12:0] + 13'd1] = wd[15:8];
        end
        default: begin
          for (k = 0; k < 4; k++) begin
            shadow[addr[12:0] + k[12:0]] = wd[8*k +: 8];
          end
        end
      endcase
      exp_data.push_back(32'h0);
    end else begin
      exp_data.push_back(load_value(sz, uns, addr[12:0]));
    end
    exp_is_load.push_back(~we);
    exp_hit.push_back(hit);
    exp_acc.push_back(cycle_cnt + 1);
  endtask

  // ========================================
  // memory model
  // ========================================

  task automatic serve_transfer();
    logic [10:0] widx;
    assert (exp_mem_we.size() != 0)
      else fail_stop("memory request while no miss was predicted");
    assert (mem_we_o == exp_mem_we[0])
      else fail_stop($sformatf("Fail mem_we_o: got %h, expected %h", mem_we_o, exp_mem_we[0]));
    assert (mem_addr_o == exp_mem_addr[0])
      else fail_stop($sformatf("Fail mem_addr_o: got %h, expected %h",
                               mem_addr_o, exp_mem_addr[0]));
    widx = mem_addr_o[12:2];
    if (mem_we_o) begin
      assert (mem_wdata_o == exp_mem_data[0])
        else fail_stop($sformatf("Fail mem_wdata_o: got %h, expected %h at address %h",
                                 mem_wdata_o, exp_mem_data[0], mem_addr_o));
      ext_mem[widx] = mem_wdata_o;
    end else begin
      mem_rdata_i = ext_mem[widx];
    end
    void'(exp_mem_we.pop_front());
    void'(exp_mem_addr.pop_front());
    void'(exp_mem_data.pop_front());
  endtask

  initial begin : memory_model
    int unsigned delay;
    mem_ack_i   = 1'b0;
    mem_rdata_i = 32'h0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      mem_ack_i = 1'b0;
      if (mem_req_o) begin
        mem_rnd = lcg_step(mem_rnd);
        delay   = mem_rnd[31:30];
        repeat (delay) @(negedge clk);
        serve_transfer();
        mem_ack_i = 1'b1;
      end
    end
  end

  // ========================================
  // response check and timeout
  // ========================================

  always @(negedge clk) begin : rsp_check
    int unsigned want;
    if (rst_n === 1'b1 && rsp_valid_o === 1'b1) begin
      assert (exp_is_load.size() != 0)
        else fail_stop("response arrived with no request outstanding");
      // hits leave two edges after acceptance, or one after the previous response
      if (exp_hit[0]) begin
        want = exp_acc[0] + 2;
        if (last_rsp + 1 > want) begin
          want = last_rsp + 1;
        end
        assert (cycle_cnt == want)
          else fail_stop($sformatf("Fail rsp_valid_o: at cycle %h, expected cycle %h",
                                   cycle_cnt, want));
      end
      if (exp_is_load[0]) begin
        assert (rsp_rdata_o == exp_data[0])
          else fail_stop($sformatf("Fail rsp_rdata_o: got %h, expected %h",
                                   rsp_rdata_o, exp_data[0]));
      end
      last_rsp = cycle_cnt;
      void'(exp_is_load.pop_front());
      void'(exp_data.pop_front());
      void'(exp_hit.pop_front());
      void'(exp_acc.pop_front());
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      fail_stop("run did not finish within the cycle limit");
    end
  end

  // ========================================
  // stimulus
  // ========================================

  initial begin : stimulus
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [12:0] a;
    logic [8:0]  prev_line;
    mem_size_e   sz;
    int          i;
    int          w;
    int          n;
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = SIZE_WORD;
    req_unsigned_i = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = 32'h0;
    prev_line      = '0;
    for (i = 0; i < MEM_WORDS; i++) begin
      ext_mem[i] = fill_word(i);
      for (w = 0; w < 4; w++) begin
        shadow[4*i + w] = ext_mem[i][8*w +: 8];
      end
    end
    for (i = 0; i < NUM_SETS; i++) begin
      m_plru[i] = 1'b0;
      for (w = 0; w < `DC_WAYS; w++) begin
        m_tag[i][w]   = '0;
        m_valid[i][w] = 1'b0;
        m_dirty[i][w] = 1'b0;
      end
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (req_ready_o === 1'b1 && rsp_valid_o === 1'b0 && mem_req_o === 1'b0)
      else fail_stop($sformatf("Fail reset state: req_ready_o %h rsp_valid_o %h mem_req_o %h",
                               req_ready_o, rsp_valid_o, mem_req_o));

    for (n = 0; n < NUM_REQS; n++) begin
      r1 = next_stim_rand();
      // occasional bubble
      if (r1[31:29] == 3'd0) begin
        req_valid_i = 1'b0;
        @(negedge clk);
      end
      r2 = next_stim_rand();
      r3 = next_stim_rand();
      // half the time stay on the last line, so hits come back to back
      if (r2[31] && n != 0) begin
        a = {prev_line, r2[19:16]};
      end else begin
        a = r2[28:16];
      end
      case (r2[15:14])
        2'd0:    sz = SIZE_BYTE;
        2'd1:    sz = SIZE_HALF;
        default: sz = SIZE_WORD;
      endcase
      if (sz == SIZE_HALF) begin
        a[0] = 1'b0;
      end else if (sz == SIZE_WORD) begin
        a[1:0] = 2'b00;
      end
      prev_line      = a[12:4];
      req_valid_i    = 1'b1;
      req_we_i       = r2[30];
      req_size_i     = sz;
      req_unsigned_i = r2[29];
      req_addr_i     = {19'b0, a};
      req_wdata_i    = r3;
      // ready is settled here, it only moves after a rising edge
      while (!req_ready_o) @(negedge clk);
      predict(req_we_i, sz, req_unsigned_i, req_addr_i, req_wdata_i);
      @(negedge clk);
    end
    req_valid_i = 1'b0;

    while (exp_is_load.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    if (exp_mem_we.size() == 0 && !mem_req_o) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_stop("memory traffic left over after the last response");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_sdp_ram.sv
src/dcache_arrays.sv
src/dcache_lookup.sv
src/dcache_access.sv
src/dcache_miss_fsm.sv
src/dcache_top.sv
tb/tb_dcache.sv
